// ==== filelist.f ====
+incdir+src
src/periph_pkg.sv
src/periph_reg_if.sv
src/periph_bus_decoder.sv
src/periph_gpio.sv
src/periph_timer.sv
src/periph_irq_ctrl.sv
src/periph_minimal.sv
verif/tb_periph_minimal.sv

// ==== src/periph_bus_decoder.sv ====
// wishbone classic slave that decodes the window and routes accesses to the blocks
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_bus_decoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  periph_pkg::word_t    wb_adr,
    input  periph_pkg::word_t    wb_dat_w,
    output periph_pkg::word_t    wb_dat_r,
    output logic                 wb_ack,
    periph_reg_if.decoder        reg_irq,
    periph_reg_if.decoder        reg_gpio,
    periph_reg_if.decoder        reg_timer
);

    periph_pkg::bus_state_e state_q;
    periph_pkg::word_t      rel_addr;
    periph_pkg::offset_t    offset;
    logic                   in_window;
    logic                   req;

    assign in_window = (wb_adr >= `PERIPH_BASE) && (wb_adr < `PERIPH_BASE + `PERIPH_SIZE);
    assign rel_addr  = wb_adr - `PERIPH_BASE;
    assign offset    = rel_addr[`OFFSET_W-1:0];

    // only the first cycle of a request is served, a held stb waits for idle
    assign req = wb_cyc && wb_stb && in_window && (state_q == periph_pkg::bus_idle);

    // irq block starts at offset 0
    assign reg_irq.sel   = req && (offset < `IRQ_OFF + `IRQ_SIZE);
    assign reg_gpio.sel  = req && (offset >= `GPIO_OFF) && (offset < `GPIO_OFF + `GPIO_SIZE);
    assign reg_timer.sel = req && (offset >= `TIMER_OFF);

    assign reg_irq.offset   = periph_pkg::offset_t'(offset - `IRQ_OFF);
    assign reg_gpio.offset  = periph_pkg::offset_t'(offset - `GPIO_OFF);
    assign reg_timer.offset = periph_pkg::offset_t'(offset - `TIMER_OFF);

    assign reg_irq.we   = wb_we;
    assign reg_gpio.we  = wb_we;
    assign reg_timer.we = wb_we;

    assign reg_irq.wdata   = wb_dat_w;
    assign reg_gpio.wdata  = wb_dat_w;
    assign reg_timer.wdata = wb_dat_w;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= periph_pkg::bus_idle;
        end
        else if (state_q == periph_pkg::bus_idle)
        begin
            if (req)
            begin
                state_q <= periph_pkg::bus_ack;
            end
        end
        else
        begin
            state_q <= periph_pkg::bus_idle;
        end
    end

    // unselected blocks drive zero
    always_ff @(posedge clk)
    begin
        if (req)
        begin
            wb_dat_r <= reg_irq.rdata | reg_gpio.rdata | reg_timer.rdata;
        end
    end

    assign wb_ack = (state_q == periph_pkg::bus_ack);

endmodule

// ==== src/periph_consts.svh ====
// peripheral window constants: memory map, register counts and timer prescale
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// first bus address of the peripheral window
`define PERIPH_BASE 8'hEE

// register count of each block
`define IRQ_SIZE   4
`define GPIO_SIZE  8
`define TIMER_SIZE 3

// blocks are packed back to back from offset 0
`define IRQ_OFF   0
`define GPIO_OFF  (`IRQ_OFF + `IRQ_SIZE)
`define TIMER_OFF (`GPIO_OFF + `GPIO_SIZE)

// whole window
`define PERIPH_SIZE (`IRQ_SIZE + `GPIO_SIZE + `TIMER_SIZE)
`define OFFSET_W    4

// clock cycles per timer tick
`define TIMER_PRESCALE 4

`endif

// ==== src/periph_gpio.sv ====
// 16-bit gpio port with output latches, synchronized inputs and rising-edge interrupt
`timescale 1ns/1ps

module periph_gpio (
    input  logic                  clk,
    input  logic                  rst,
    periph_reg_if.peripheral      regs,
    input  periph_pkg::gpio_bus_t gpi,
    output periph_pkg::gpio_bus_t gpo,
    output logic                  irq
);

    periph_pkg::gpio_bus_t gpo_q;
    periph_pkg::gpio_bus_t mask_q;
    periph_pkg::gpio_bus_t flag_q;
    periph_pkg::gpio_bus_t gpi_meta;
    periph_pkg::gpio_bus_t gpi_sync;
    periph_pkg::gpio_bus_t gpi_prev;
    periph_pkg::gpio_bus_t rise;
    periph_pkg::gpio_bus_t flag_clr;
    logic                  wr;

    assign wr = regs.sel && regs.we;

    // two-flop synchronizer plus one stage for edge detect
    always_ff @(posedge clk)
    begin
        gpi_meta <= gpi;
        gpi_sync <= gpi_meta;
        gpi_prev <= gpi_sync;
    end

    assign rise = gpi_sync & ~gpi_prev;

    always_comb
    begin
        flag_clr = '0;
        if (wr && regs.offset == 4'd6)
        begin
            flag_clr[7:0] = regs.wdata;
        end
        if (wr && regs.offset == 4'd7)
        begin
            flag_clr[15:8] = regs.wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            gpo_q  <= '0;
            mask_q <= '0;
            flag_q <= '0;
        end
        else
        begin
            if (wr)
            begin
                case (regs.offset)
                    4'd0: gpo_q[7:0]   <= regs.wdata;
                    4'd1: gpo_q[15:8]  <= regs.wdata;
                    4'd4: mask_q[7:0]  <= regs.wdata;
                    4'd5: mask_q[15:8] <= regs.wdata;
                    default: ;
                endcase
            end
            // an edge in the clearing cycle keeps its flag
            flag_q <= (flag_q & ~flag_clr) | rise;
        end
    end

    always_comb
    begin
        regs.rdata = '0;
        if (regs.sel)
        begin
            case (regs.offset)
                4'd0: regs.rdata = gpo_q[7:0];
                4'd1: regs.rdata = gpo_q[15:8];
                4'd2: regs.rdata = gpi_sync[7:0];
                4'd3: regs.rdata = gpi_sync[15:8];
                4'd4: regs.rdata = mask_q[7:0];
                4'd5: regs.rdata = mask_q[15:8];
                4'd6: regs.rdata = flag_q[7:0];
                4'd7: regs.rdata = flag_q[15:8];
                default: regs.rdata = '0;
            endcase
        end
    end

    assign gpo = gpo_q;
    assign irq = |(flag_q & mask_q);

endmodule

// ==== src/periph_irq_ctrl.sv ====
// interrupt controller with pending, enable and software trigger driving the cpu lines
`timescale 1ns/1ps

module periph_irq_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    periph_reg_if.peripheral     regs,
    input  periph_pkg::irq_vec_t src,
    output periph_pkg::irq_vec_t cpu_irq
);

    periph_pkg::irq_vec_t enable_q;
    periph_pkg::irq_vec_t pending_q;
    periph_pkg::irq_vec_t active;
    periph_pkg::irq_vec_t clr;
    periph_pkg::irq_vec_t sw_set;
    periph_pkg::irq_vec_t cpu_irq_q;
    logic                 wr;

    assign wr     = regs.sel && regs.we;
    assign clr    = (wr && regs.offset == 4'd1) ? regs.wdata[3:0] : '0;
    assign sw_set = (wr && regs.offset == 4'd2) ? regs.wdata[3:0] : '0;
    assign active = pending_q & enable_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            enable_q  <= '0;
            pending_q <= '0;
            cpu_irq_q <= '0;
        end
        else
        begin
            if (wr && regs.offset == 4'd0)
            begin
                enable_q <= regs.wdata[3:0];
            end
            // a source still high sets its bit again
            pending_q <= (pending_q & ~clr) | src | sw_set;
            cpu_irq_q <= active;
        end
    end

    // software trigger reads back as zero
    always_comb
    begin
        regs.rdata = '0;
        if (regs.sel)
        begin
            case (regs.offset)
                4'd0: regs.rdata = {4'b0, enable_q};
                4'd1: regs.rdata = {4'b0, pending_q};
                4'd3: regs.rdata = {4'b0, active};
                default: regs.rdata = '0;
            endcase
        end
    end

    assign cpu_irq = cpu_irq_q;

endmodule

// ==== src/periph_minimal.sv ====
// peripheral subsystem top: wishbone slave with irq controller, gpio and timer
`timescale 1ns/1ps

module periph_minimal (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  periph_pkg::word_t     wb_adr,
    input  periph_pkg::word_t     wb_dat_w,
    output periph_pkg::word_t     wb_dat_r,
    output logic                  wb_ack,
    input  periph_pkg::gpio_bus_t gpi,
    output periph_pkg::gpio_bus_t gpo,
    input  logic [1:0]            irq_in,
    output periph_pkg::irq_vec_t  cpu_irq
);

    periph_pkg::irq_vec_t src;
    logic                 gpio_irq;
    logic                 timer_irq;

    periph_reg_if reg_irq ();
    periph_reg_if reg_gpio ();
    periph_reg_if reg_timer ();

    // external pins take the two upper source slots
    assign src[periph_pkg::src_gpio]  = gpio_irq;
    assign src[periph_pkg::src_timer] = timer_irq;
    assign src[periph_pkg::src_ext0]  = irq_in[0];
    assign src[periph_pkg::src_ext1]  = irq_in[1];

    periph_bus_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .reg_irq   (reg_irq.decoder),
        .reg_gpio  (reg_gpio.decoder),
        .reg_timer (reg_timer.decoder)
    );

    periph_gpio u_gpio (
        .clk  (clk),
        .rst  (rst),
        .regs (reg_gpio.peripheral),
        .gpi  (gpi),
        .gpo  (gpo),
        .irq  (gpio_irq)
    );

    periph_timer u_timer (
        .clk  (clk),
        .rst  (rst),
        .regs (reg_timer.peripheral),
        .irq  (timer_irq)
    );

    periph_irq_ctrl u_irq_ctrl (
        .clk     (clk),
        .rst     (rst),
        .regs    (reg_irq.peripheral),
        .src     (src),
        .cpu_irq (cpu_irq)
    );

endmodule

// ==== src/periph_pkg.sv ====
// shared data types and enums of the peripheral subsystem
`include "periph_consts.svh"

package periph_pkg;

    // bus data word
    typedef logic [7:0] word_t;

    // register offset inside the window or inside one block
    typedef logic [`OFFSET_W-1:0] offset_t;

    // gpio pin vector
    typedef logic [15:0] gpio_bus_t;

    // one bit per interrupt source
    typedef logic [3:0] irq_vec_t;

    // index of each interrupt source in an irq_vec_t
    typedef enum logic [1:0] {
        src_gpio  = 2'd0,
        src_timer = 2'd1,
        src_ext0  = 2'd2,
        src_ext1  = 2'd3
    } irq_src_e;

    // wishbone decoder FSM
    typedef enum logic {
        bus_idle,
        bus_ack
    } bus_state_e;

    // timer control bits 1:0
    typedef enum logic [1:0] {
        mode_stopped  = 2'd0,
        mode_one_shot = 2'd1,
        mode_periodic = 2'd2
    } timer_mode_e;

endpackage

// ==== src/periph_reg_if.sv ====
// register access channel from the bus decoder to one peripheral block
`timescale 1ns/1ps

interface periph_reg_if;

    logic                sel;
    logic                we;
    periph_pkg::offset_t offset;
    periph_pkg::word_t   wdata;
    // zero while sel is low, so the decoder can OR all blocks
    periph_pkg::word_t   rdata;

    modport decoder (
        output sel, we, offset, wdata,
        input  rdata
    );

    modport peripheral (
        input  sel, we, offset, wdata,
        output rdata
    );

endinterface

// ==== src/periph_timer.sv ====
// prescaled 8-bit down-counter with stopped, one-shot and periodic modes
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_timer (
    input  logic             clk,
    input  logic             rst,
    periph_reg_if.peripheral regs,
    output logic             irq
);

    periph_pkg::timer_mode_e              mode_q;
    periph_pkg::timer_mode_e              wr_mode;
    periph_pkg::word_t                    reload_q;
    periph_pkg::word_t                    count_q;
    logic [$clog2(`TIMER_PRESCALE)-1:0]   presc_q;
    logic                                 tick;
    logic                                 ctrl_wr;
    logic                                 irq_q;

    assign ctrl_wr = regs.sel && regs.we && (regs.offset == 4'd0);
    assign tick    = (presc_q == `TIMER_PRESCALE - 1);

    // encoding 3 is not a mode, treat it as stop
    always_comb
    begin
        case (periph_pkg::timer_mode_e'(regs.wdata[1:0]))
            periph_pkg::mode_one_shot: wr_mode = periph_pkg::mode_one_shot;
            periph_pkg::mode_periodic: wr_mode = periph_pkg::mode_periodic;
            default:                   wr_mode = periph_pkg::mode_stopped;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (regs.sel && regs.we && regs.offset == 4'd1)
        begin
            reload_q <= regs.wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mode_q  <= periph_pkg::mode_stopped;
            count_q <= '0;
            presc_q <= '0;
            irq_q   <= 1'b0;
        end
        else
        begin
            irq_q <= 1'b0;
            if (ctrl_wr)
            begin
                mode_q  <= wr_mode;
                presc_q <= '0;
                if (wr_mode != periph_pkg::mode_stopped)
                begin
                    count_q <= reload_q;
                end
            end
            else if (mode_q != periph_pkg::mode_stopped)
            begin
                presc_q <= tick ? '0 : presc_q + 1'b1;
                if (tick)
                begin
                    if (count_q == '0)
                    begin
                        irq_q <= 1'b1;
                        if (mode_q == periph_pkg::mode_periodic)
                        begin
                            count_q <= reload_q;
                        end
                        else
                        begin
                            mode_q <= periph_pkg::mode_stopped;
                        end
                    end
                    else
                    begin
                        count_q <= count_q - 1'b1;
                    end
                end
            end
        end
    end

    always_comb
    begin
        regs.rdata = '0;
        if (regs.sel)
        begin
            case (regs.offset)
                4'd0: regs.rdata = {6'b0, mode_q};
                4'd1: regs.rdata = reload_q;
                4'd2: regs.rdata = count_q;
                default: regs.rdata = '0;
            endcase
        end
    end

    assign irq = irq_q;

endmodule

// ==== verif/tb_periph_minimal.sv ====
// directed testbench for the peripheral subsystem covering bus decode, gpio, timer and irq controller
`timescale 1ns/1ps
`include "periph_consts.svh"

module tb_periph_minimal;

    // register addresses from the memory map
    localparam periph_pkg::word_t adr_irq_enable  = `PERIPH_BASE + `IRQ_OFF + 0;
    localparam periph_pkg::word_t adr_irq_pending = `PERIPH_BASE + `IRQ_OFF + 1;
    localparam periph_pkg::word_t adr_irq_trigger = `PERIPH_BASE + `IRQ_OFF + 2;
    localparam periph_pkg::word_t adr_irq_active  = `PERIPH_BASE + `IRQ_OFF + 3;
    localparam periph_pkg::word_t adr_gpo_lo      = `PERIPH_BASE + `GPIO_OFF + 0;
    localparam periph_pkg::word_t adr_gpo_hi      = `PERIPH_BASE + `GPIO_OFF + 1;
    localparam periph_pkg::word_t adr_gpi_lo      = `PERIPH_BASE + `GPIO_OFF + 2;
    localparam periph_pkg::word_t adr_gpi_hi      = `PERIPH_BASE + `GPIO_OFF + 3;
    localparam periph_pkg::word_t adr_mask_lo     = `PERIPH_BASE + `GPIO_OFF + 4;
    localparam periph_pkg::word_t adr_mask_hi     = `PERIPH_BASE + `GPIO_OFF + 5;
    localparam periph_pkg::word_t adr_flag_lo     = `PERIPH_BASE + `GPIO_OFF + 6;
    localparam periph_pkg::word_t adr_flag_hi     = `PERIPH_BASE + `GPIO_OFF + 7;
    localparam periph_pkg::word_t adr_tmr_ctrl    = `PERIPH_BASE + `TIMER_OFF + 0;
    localparam periph_pkg::word_t adr_tmr_reload  = `PERIPH_BASE + `TIMER_OFF + 1;
    localparam periph_pkg::word_t adr_tmr_count   = `PERIPH_BASE + `TIMER_OFF + 2;

    // reload 3 gives (reload + 1) ticks plus one prescale period of phase
    localparam int timer_limit = (3 + 2) * `TIMER_PRESCALE;
    // the tests take roughly a thousand cycles
    localparam int max_cycles  = 5000;

    logic                  clk;
    logic                  rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    periph_pkg::word_t     wb_adr;
    periph_pkg::word_t     wb_dat_w;
    periph_pkg::word_t     wb_dat_r;
    logic                  wb_ack;
    periph_pkg::gpio_bus_t gpi;
    periph_pkg::gpio_bus_t gpo;
    logic [1:0]            irq_in;
    periph_pkg::irq_vec_t  cpu_irq;

    integer seed;
    int     cycles;
    int     errors;
    int     tests_ok;
    int     tests_bad;

    periph_minimal dut0 (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .gpi      (gpi),
        .gpo      (gpo),
        .irq_in   (irq_in),
        .cpu_irq  (cpu_irq)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic periph_pkg::irq_vec_t src_mask(input periph_pkg::irq_src_e s);
        src_mask = periph_pkg::irq_vec_t'(1) << s;
    endfunction

    task automatic report_fail(input string msg);
        errors++;
        $display("at %0t ns: %s", $time, msg);
    endtask

    task automatic check_word(input string name, input periph_pkg::word_t got,
                              input periph_pkg::word_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0t ns: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
        end
    endtask

    task automatic check_pins(input string name, input periph_pkg::gpio_bus_t got,
                              input periph_pkg::gpio_bus_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0t ns: %s = 0x%04h, expected 0x%04h", $time, name, got, exp);
        end
    endtask

    task automatic check_irq(input string name, input periph_pkg::irq_vec_t got,
                             input periph_pkg::irq_vec_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0t ns: %s = 0x%01h, expected 0x%01h", $time, name, got, exp);
        end
    endtask

    // every task starts and ends 1 ns after a rising edge
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wb_cycle(input periph_pkg::word_t adr, input logic we,
                            input periph_pkg::word_t wdat, output periph_pkg::word_t rdat);
        int n;
        n = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        while (!wb_ack && n < 4)
        begin
            idle_cycles(1);
            n++;
        end
        if (!wb_ack)
            report_fail($sformatf("no ack within 4 cycles at address 0x%02h", adr));
        else if (n != 1)
            report_fail($sformatf("ack on cycle %0d instead of cycle 1 at 0x%02h", n, adr));
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        idle_cycles(1);
        if (wb_ack)
            report_fail($sformatf("ack lasted more than one cycle at address 0x%02h", adr));
    endtask

    task automatic wb_write(input periph_pkg::word_t adr, input periph_pkg::word_t data);
        periph_pkg::word_t unused;
        wb_cycle(adr, 1'b1, data, unused);
    endtask

    task automatic wb_read(input periph_pkg::word_t adr, output periph_pkg::word_t data);
        wb_cycle(adr, 1'b0, 8'h00, data);
    endtask

    task automatic expect_no_ack(input periph_pkg::word_t adr, input logic we);
        logic seen;
        seen     = 1'b0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = 8'h5a;
        repeat (4)
        begin
            idle_cycles(1);
            seen = seen | wb_ack;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (seen)
            report_fail($sformatf("access outside the window at 0x%02h was acked", adr));
    endtask

    task automatic wait_irq(input periph_pkg::irq_src_e s, input int limit);
        int n;
        n = 0;
        while (!cpu_irq[s] && n < limit)
        begin
            idle_cycles(1);
            n++;
        end
        if (!cpu_irq[s])
            report_fail($sformatf("cpu_irq bit %0d not raised within %0d cycles", s, limit));
    endtask

    task automatic finish_test(input string name, input int err_start);
        if (errors == err_start)
        begin
            tests_ok++;
            $display("[%s] ok", name);
        end
        else
        begin
            tests_bad++;
            $display("[%s] %0d errors", name, errors - err_start);
        end
    endtask

    task automatic test_bus_decode();
        int                err_start;
        periph_pkg::word_t adr;
        periph_pkg::word_t rd;
        err_start = errors;
        if (wb_ack)
            report_fail("wb_ack high after reset");
        check_pins("gpo", gpo, 16'h0000);
        check_irq("cpu_irq", cpu_irq, 4'h0);
        // each of the 15 registers acks once and reads zero after reset
        for (int a = 0; a < `PERIPH_SIZE; a++)
        begin
            adr = periph_pkg::word_t'(`PERIPH_BASE + a);
            wb_read(adr, rd);
            // the timer reload powers up unknown
            if (a != `TIMER_OFF + 1)
                check_word($sformatf("reg[0x%02h]", adr), rd, 8'h00);
        end
        wb_write(adr_irq_enable, 8'h05);
        wb_read(adr_irq_enable, rd);
        check_word("irq_enable", rd, 8'h05);
        wb_write(adr_irq_enable, 8'h00);
        expect_no_ack(8'hed, 1'b1);
        expect_no_ack(8'hed, 1'b0);
        expect_no_ack(8'hfd, 1'b1);
        expect_no_ack(8'hfd, 1'b0);
        finish_test("bus_decode", err_start);
    endtask

    task automatic test_gpio_out();
        int                err_start;
        periph_pkg::word_t lo;
        periph_pkg::word_t hi;
        periph_pkg::word_t rd;
        err_start = errors;
        for (int i = 0; i < 4; i++)
        begin
            lo = $random(seed);
            hi = $random(seed);
            wb_write(adr_gpo_lo, lo);
            wb_write(adr_gpo_hi, hi);
            check_pins("gpo", gpo, {hi, lo});
            wb_read(adr_gpo_lo, rd);
            check_word("gpo_lo", rd, lo);
            wb_read(adr_gpo_hi, rd);
            check_word("gpo_hi", rd, hi);
        end
        finish_test("gpio_out", err_start);
    endtask

    task automatic test_gpio_in();
        int                err_start;
        periph_pkg::word_t rd;
        err_start = errors;
        gpi = $random(seed);
        idle_cycles(3);
        wb_read(adr_gpi_lo, rd);
        check_word("gpi_lo", rd, gpi[7:0]);
        wb_read(adr_gpi_hi, rd);
        check_word("gpi_hi", rd, gpi[15:8]);
        // quiet pins and drop the flags left by the random value
        gpi = '0;
        idle_cycles(4);
        wb_write(adr_flag_lo, 8'hff);
        wb_write(adr_flag_hi, 8'hff);
        wb_write(adr_irq_pending, 8'h0f);
        wb_write(adr_mask_lo, 8'h20);
        wb_write(adr_irq_enable, periph_pkg::word_t'(src_mask(periph_pkg::src_gpio)));
        gpi[5] = 1'b1;
        wait_irq(periph_pkg::src_gpio, 8);
        check_irq("cpu_irq", cpu_irq, src_mask(periph_pkg::src_gpio));
        wb_read(adr_flag_lo, rd);
        check_word("flag_lo", rd, 8'h20);
        // pending stays latched until the flag is gone and pending is cleared
        wb_write(adr_flag_lo, 8'h20);
        wb_write(adr_irq_pending, periph_pkg::word_t'(src_mask(periph_pkg::src_gpio)));
        check_irq("cpu_irq", cpu_irq, 4'h0);
        wb_write(adr_mask_lo, 8'h00);
        wb_write(adr_irq_enable, 8'h00);
        gpi = '0;
        finish_test("gpio_in", err_start);
    endtask

    task automatic test_timer();
        int                err_start;
        int                t0;
        periph_pkg::word_t rd;
        periph_pkg::word_t prev;
        err_start = errors;
        wb_write(adr_irq_pending, 8'h0f);
        wb_write(adr_irq_enable, periph_pkg::word_t'(src_mask(periph_pkg::src_timer)));
        wb_write(adr_tmr_reload, 8'd3);
        wb_write(adr_tmr_ctrl, periph_pkg::word_t'(periph_pkg::mode_one_shot));
        t0   = cycles;
        prev = 8'hff;
        while (!cpu_irq[periph_pkg::src_timer] && cycles - t0 < 2 * timer_limit)
        begin
            wb_read(adr_tmr_count, rd);
            if (rd > prev)
                report_fail($sformatf("timer count rose from %0d to %0d", prev, rd));
            prev = rd;
        end
        if (!cpu_irq[periph_pkg::src_timer])
            report_fail("one-shot timer never raised its interrupt");
        else if (cycles - t0 > timer_limit)
            report_fail($sformatf("one-shot interrupt took %0d cycles", cycles - t0));
        wb_read(adr_irq_pending, rd);
        check_word("irq_pending", rd, periph_pkg::word_t'(src_mask(periph_pkg::src_timer)));
        wb_read(adr_tmr_ctrl, rd);
        check_word("tmr_ctrl", rd, periph_pkg::word_t'(periph_pkg::mode_stopped));
        wb_write(adr_irq_pending, periph_pkg::word_t'(src_mask(periph_pkg::src_timer)));
        check_irq("cpu_irq", cpu_irq, 4'h0);
        // periodic mode fires again after each clear
        wb_write(adr_tmr_ctrl, periph_pkg::word_t'(periph_pkg::mode_periodic));
        repeat (2)
        begin
            wait_irq(periph_pkg::src_timer, timer_limit);
            wb_write(adr_irq_pending, periph_pkg::word_t'(src_mask(periph_pkg::src_timer)));
            check_irq("cpu_irq", cpu_irq, 4'h0);
        end
        wb_write(adr_tmr_ctrl, periph_pkg::word_t'(periph_pkg::mode_stopped));
        wb_write(adr_irq_pending, 8'h0f);
        wb_write(adr_irq_enable, 8'h00);
        finish_test("timer", err_start);
    endtask

    task automatic test_irq_ctrl();
        int                   err_start;
        periph_pkg::word_t    rd;
        periph_pkg::irq_vec_t pend;
        periph_pkg::irq_vec_t en;
        err_start = errors;
        wb_write(adr_irq_pending, 8'h0f);
        wb_write(adr_irq_enable, 8'h00);
        irq_in = 2'b01;
        idle_cycles(1);
        irq_in = 2'b00;
        idle_cycles(1);
        pend = src_mask(periph_pkg::src_ext0);
        wb_read(adr_irq_pending, rd);
        check_word("irq_pending", rd, periph_pkg::word_t'(pend));
        check_irq("cpu_irq", cpu_irq, 4'h0);
        wb_write(adr_irq_trigger, periph_pkg::word_t'(src_mask(periph_pkg::src_ext1)));
        pend = pend | src_mask(periph_pkg::src_ext1);
        wb_read(adr_irq_trigger, rd);
        check_word("irq_trigger", rd, 8'h00);
        wb_read(adr_irq_pending, rd);
        check_word("irq_pending", rd, periph_pkg::word_t'(pend));
        en = src_mask(periph_pkg::src_timer) | src_mask(periph_pkg::src_ext1);
        wb_write(adr_irq_enable, periph_pkg::word_t'(en));
        wb_read(adr_irq_active, rd);
        check_word("irq_active", rd, periph_pkg::word_t'(pend & en));
        check_irq("cpu_irq", cpu_irq, pend & en);
        // a source still high survives the clear
        irq_in = 2'b01;
        wb_write(adr_irq_pending, periph_pkg::word_t'(src_mask(periph_pkg::src_ext0)));
        wb_read(adr_irq_pending, rd);
        check_word("irq_pending", rd, periph_pkg::word_t'(pend));
        irq_in = 2'b00;
        wb_write(adr_irq_pending, periph_pkg::word_t'(pend));
        wb_read(adr_irq_pending, rd);
        check_word("irq_pending", rd, 8'h00);
        check_irq("cpu_irq", cpu_irq, 4'h0);
        wb_write(adr_irq_enable, 8'h00);
        finish_test("irq_ctrl", err_start);
    endtask

    initial
    begin
        clk       = 1'b0;
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        gpi       = '0;
        irq_in    = 2'b00;
        seed      = 32'h6b0a;
        cycles    = 0;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        idle_cycles(5);
        rst = 1'b0;
        test_bus_decode();
        test_gpio_out();
        test_gpio_in();
        test_timer();
        test_irq_ctrl();
        $display("%0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (errors == 0 && tests_bad == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
